// File: logic/uartPkg.sv
// ------------------------------------------------------------
// serial side types
// ------------------------------------------------------------

package uartPkg;

  // one data byte
  // same width on the line, in the FIFO and on the block port
  typedef logic [7:0] byte_t;

  // clocks counted within one serial bit
  // also the type of the clocksPerBit parameter
  typedef logic [15:0] bitTimer_t;

endpackage

// File: logic/blockPkg.sv
// ------------------------------------------------------------
// block side types
// ------------------------------------------------------------

package blockPkg;

  // card sector address
  typedef logic [31:0] sector_t;

  // sectors written since reset
  // stands in for the growing file length
  typedef logic [31:0] sectorCount_t;

  // sector writer FSM
  // waitBlock    idle until a whole block is queued
  // fetchFirst   first pop in flight
  // startBlock   byte 0 lands in wrByte, wrStart goes out
  // streamBytes  prefetch on every byteTaken
  // awaitDone    last byte taken, card still busy
  typedef enum logic [2:0] {
    waitBlock,
    fetchFirst,
    startBlock,
    streamBytes,
    awaitDone
  } writerState_t;

endpackage

// File: logic/uartReceiver.sv
`timescale 1ns/100ps

module uartReceiver #(
  parameter uartPkg::bitTimer_t clocksPerBit = 174
) (
  input  logic           clk,
  input  logic           rstn,
  input  logic           rx,
  output uartPkg::byte_t rxByte,
  output logic           rxValid
);

  import uartPkg::*;

  // ------------------------------------------------------------
  // bit timing
  // ------------------------------------------------------------

  // last clock of a full bit
  localparam bitTimer_t lastTick = clocksPerBit - bitTimer_t'(1);
  // middle of the start bit, counted from the falling edge
  localparam bitTimer_t midTick = (clocksPerBit >> 1) - bitTimer_t'(1);

  typedef enum logic [1:0] {
    rxIdle,
    rxStart,
    rxData,
    rxStop
  } rxState_t;

  rxState_t   state;
  bitTimer_t  timer;
  logic [2:0] bitIdx;
  logic [1:0] rxSync;
  logic       rxIn;
  logic       sampleData;
  byte_t      shiftReg;

  // two flop synchronizer, line idles high
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rxSync <= 2'b11;
    end else begin
      rxSync <= {rxSync[0], rx};
    end
  end

  assign rxIn = rxSync[1];

  // middle of a data bit
  assign sampleData = (state == rxData) && (timer == lastTick);

  // ------------------------------------------------------------
  // receive FSM
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state   <= rxIdle;
      timer   <= '0;
      bitIdx  <= '0;
      rxValid <= 1'b0;
    end else begin
      // strobe lasts one clock
      rxValid <= 1'b0;
      case (state)
        rxIdle: begin
          // falling edge of the start bit
          if (!rxIn) begin
            state <= rxStart;
            timer <= '0;
          end
        end
        rxStart: begin
          if (timer == midTick) begin
            timer  <= '0;
            bitIdx <= '0;
            // still low at mid bit, else a glitch
            if (!rxIn) begin
              state <= rxData;
            end else begin
              state <= rxIdle;
            end
          end else begin
            timer <= timer + bitTimer_t'(1);
          end
        end
        rxData: begin
          if (sampleData) begin
            timer  <= '0;
            bitIdx <= bitIdx + 3'd1;
            if (bitIdx == 3'd7) begin
              state <= rxStop;
            end
          end else begin
            timer <= timer + bitTimer_t'(1);
          end
        end
        rxStop: begin
          if (timer == lastTick) begin
            timer <= '0;
            state <= rxIdle;
            // framing error drops the byte
            rxValid <= rxIn;
          end else begin
            timer <= timer + bitTimer_t'(1);
          end
        end
        default: begin
          state <= rxIdle;
        end
      endcase
    end
  end

  // data comes lsb first
  always_ff @(posedge clk) begin
    if (sampleData) begin
      shiftReg <= {rxIn, shiftReg[7:1]};
    end
  end

  // shift register is stable from the last data bit on
  assign rxByte = shiftReg;

endmodule

// File: logic/byteFifo.sv
`timescale 1ns/100ps

module byteFifo #(
  parameter int fifoAddrBits = 12
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  push,
  input  uartPkg::byte_t        pushByte,
  input  logic                  pop,
  output uartPkg::byte_t        popByte,
  output logic [fifoAddrBits:0] level,
  output logic                  overflow
);

  import uartPkg::*;

  localparam int depth = 1 << fifoAddrBits;

  // storage
  byte_t mem [depth];

  // pointers carry one wrap bit above the address
  logic [fifoAddrBits:0] wrPtr;
  logic [fifoAddrBits:0] rdPtr;
  logic                  full;
  logic                  empty;
  logic                  doPush;
  logic                  doPop;

  // ------------------------------------------------------------
  // fill level and flags
  // ------------------------------------------------------------

  // wrap bit makes the difference exact up to depth
  assign level = wrPtr - rdPtr;
  // only a full buffer sets the top bit
  assign full  = level[fifoAddrBits];
  assign empty = (level == '0);

  // byte that meets a full buffer is lost
  assign doPush = push && !full;
  assign doPop  = pop && !empty;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      overflow <= 1'b0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + (fifoAddrBits + 1)'(1);
      end
      if (doPop) begin
        rdPtr <= rdPtr + (fifoAddrBits + 1)'(1);
      end
      // sticky until reset
      if (push && full) begin
        overflow <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // memory and registered read port
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr[fifoAddrBits-1:0]] <= pushByte;
    end
    // popped byte holds until the next pop
    if (doPop) begin
      popByte <= mem[rdPtr[fifoAddrBits-1:0]];
    end
  end

endmodule

// File: logic/sectorWriter.sv
`timescale 1ns/100ps

module sectorWriter #(
  parameter int               blockBytes   = 512,
  parameter int               fifoAddrBits = 12,
  parameter blockPkg::sector_t baseSector  = 0
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic [fifoAddrBits:0]  level,
  output logic                   pop,
  input  uartPkg::byte_t         popByte,
  output logic                   wrStart,
  output blockPkg::sector_t      wrSector,
  output uartPkg::byte_t         wrByte,
  input  logic                   byteTaken,
  input  logic                   blockDone,
  output logic                   blockBusy,
  output blockPkg::sectorCount_t sectorsWritten
);

  import blockPkg::*;

  // ------------------------------------------------------------
  // block geometry
  // ------------------------------------------------------------

  // byte index width, at least one bit
  localparam int idxBits = ($clog2(blockBytes) > 0) ? $clog2(blockBytes) : 1;

  // index of the last byte in a block
  localparam logic [idxBits-1:0] lastIdx = idxBits'(blockBytes - 1);

  // fill level that holds a whole block
  localparam logic [fifoAddrBits:0] blockLevel = (fifoAddrBits + 1)'(blockBytes);

  writerState_t       state;
  logic [idxBits-1:0] byteIdx;
  // pop seen one clock ago, FIFO read data valid now
  logic               popDly;
  logic               blockReady;

  assign blockReady = (level >= blockLevel);

  // ------------------------------------------------------------
  // writer FSM
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state          <= waitBlock;
      byteIdx        <= '0;
      pop            <= 1'b0;
      popDly         <= 1'b0;
      wrStart        <= 1'b0;
      blockBusy      <= 1'b0;
      wrSector       <= baseSector;
      sectorsWritten <= '0;
    end else begin
      // pulses default low
      pop     <= 1'b0;
      wrStart <= 1'b0;
      popDly  <= pop;
      case (state)
        waitBlock: begin
          // whole block queued, fetch byte 0 ahead of wrStart
          if (blockReady) begin
            pop       <= 1'b1;
            blockBusy <= 1'b1;
            byteIdx   <= '0;
            state     <= fetchFirst;
          end
        end
        fetchFirst: begin
          // pop is out this cycle
          state <= startBlock;
        end
        startBlock: begin
          // byte 0 loads into wrByte with this edge
          wrStart <= 1'b1;
          state   <= streamBytes;
        end
        streamBytes: begin
          if (byteTaken) begin
            if (byteIdx == lastIdx) begin
              // no pop after the last byte
              state <= awaitDone;
            end else begin
              pop     <= 1'b1;
              byteIdx <= byteIdx + idxBits'(1);
            end
          end
        end
        awaitDone: begin
          // next sector and file length grow by one
          if (blockDone) begin
            wrSector       <= wrSector + sector_t'(1);
            sectorsWritten <= sectorsWritten + sectorCount_t'(1);
            blockBusy      <= 1'b0;
            state          <= waitBlock;
          end
        end
        default: begin
          state <= waitBlock;
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // outgoing byte
  // ------------------------------------------------------------

  // load one clock after each pop
  always_ff @(posedge clk) begin
    if (popDly) begin
      wrByte <= popByte;
    end
  end

endmodule

// File: logic/uartSectorLogger.sv
`timescale 1ns/100ps

module uartSectorLogger #(
  parameter uartPkg::bitTimer_t clocksPerBit = 174,
  parameter int                 blockBytes   = 512,
  parameter int                 fifoAddrBits = 12,
  parameter blockPkg::sector_t  baseSector   = 0
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   rx,
  output logic                   wrStart,
  output blockPkg::sector_t      wrSector,
  output uartPkg::byte_t         wrByte,
  input  logic                   byteTaken,
  input  logic                   blockDone,
  output logic                   blockBusy,
  output blockPkg::sectorCount_t sectorsWritten,
  output logic                   overflow
);

  import uartPkg::*;

  // receiver to FIFO
  byte_t                 rxByte;
  logic                  rxValid;

  // FIFO to writer
  logic [fifoAddrBits:0] level;
  logic                  pop;
  byte_t                 popByte;

  // ------------------------------------------------------------
  // serial in, byte queue, block out
  // ------------------------------------------------------------

  uartReceiver #(
    .clocksPerBit(clocksPerBit)
  ) receiver_i (
    .clk    (clk),
    .rstn   (rstn),
    .rx     (rx),
    .rxByte (rxByte),
    .rxValid(rxValid)
  );

  // every strobed byte is pushed, full FIFO drops it
  byteFifo #(
    .fifoAddrBits(fifoAddrBits)
  ) fifo_i (
    .clk     (clk),
    .rstn    (rstn),
    .push    (rxValid),
    .pushByte(rxByte),
    .pop     (pop),
    .popByte (popByte),
    .level   (level),
    .overflow(overflow)
  );

  sectorWriter #(
    .blockBytes  (blockBytes),
    .fifoAddrBits(fifoAddrBits),
    .baseSector  (baseSector)
  ) writer_i (
    .clk           (clk),
    .rstn          (rstn),
    .level         (level),
    .pop           (pop),
    .popByte       (popByte),
    .wrStart       (wrStart),
    .wrSector      (wrSector),
    .wrByte        (wrByte),
    .byteTaken     (byteTaken),
    .blockDone     (blockDone),
    .blockBusy     (blockBusy),
    .sectorsWritten(sectorsWritten)
  );

endmodule

// File: tb/uartSectorLoggerTb.sv
`timescale 1ns/100ps

module uartSectorLoggerTb;

  import uartPkg::*;
  import blockPkg::*;

  localparam int bitClocks   = 10;
  localparam int blockLen    = 16;
  localparam int addrBits    = 6;
  localparam int firstSector = 1000;
  // bytes sent over all tests
  localparam int totalBytes  = 15 + 1 + 32 + 16 + 66;
  // start, 8 data, stop and one idle bit per byte
  localparam int limitCycles = totalBytes * 110 + 2000;

  logic         clk;
  logic         rstn;
  logic         rx;
  logic         byteTaken;
  logic         blockDone;
  logic         wrStart;
  sector_t      wrSector;
  byte_t        wrByte;
  logic         blockBusy;
  sectorCount_t sectorsWritten;
  logic         overflow;

  // sent bytes not yet seen on the block port
  // oldest at the front
  byte_t        expQ[$];
  logic [15:0]  lfsr;
  sector_t      nextSector;
  // card holds off after wrStart while set
  logic         stall;

  uartSectorLogger #(
    .clocksPerBit(bitClocks),
    .blockBytes  (blockLen),
    .fifoAddrBits(addrBits),
    .baseSector  (firstSector)
  ) dut_i (
    .clk           (clk),
    .rstn          (rstn),
    .rx            (rx),
    .wrStart       (wrStart),
    .wrSector      (wrSector),
    .wrByte        (wrByte),
    .byteTaken     (byteTaken),
    .blockDone     (blockDone),
    .blockBusy     (blockBusy),
    .sectorsWritten(sectorsWritten),
    .overflow      (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------------------------------------
  // failure reporting and compare tasks
  // ------------------------------------------------------------

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic compareByte(input string what, input byte_t exp, input byte_t got);
    if (got !== exp) begin
      abortRun($sformatf("** Error at %0t: %s expected %02h got %02h", $time, what, exp, got));
    end
  endtask

  task automatic compareSector(input string what, input sector_t exp, input sector_t got);
    if (got !== exp) begin
      abortRun($sformatf("** Error at %0t: %s expected %0d got %0d", $time, what, exp, got));
    end
  endtask

  task automatic compareCount(input string what, input sectorCount_t exp,
                              input sectorCount_t got);
    if (got !== exp) begin
      abortRun($sformatf("** Error at %0t: %s expected %0d got %0d", $time, what, exp, got));
    end
  endtask

  task automatic compareBit(input string what, input logic exp, input logic got);
    if (got !== exp) begin
      abortRun($sformatf("** Error at %0t: %s expected %b got %b", $time, what, exp, got));
    end
  endtask

  // bounds the whole run
  initial begin
    repeat (limitCycles) @(posedge clk);
    abortRun($sformatf("watchdog expired after %0d cycles, the DUT stopped responding",
                       limitCycles));
  end

  // ------------------------------------------------------------
  // stimulus sources
  // ------------------------------------------------------------

  // galois step with taps 16 14 13 11
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  // one lfsr step per data bit
  task automatic drawByte(output byte_t b);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsrStep(lfsr);
      b[i] = lfsr[0];
    end
  endtask

  // starts and ends on a rising edge
  task automatic holdBit(input logic v);
    rx <= v;
    repeat (bitClocks) @(posedge clk);
  endtask

  // 8N1 frame lsb first and one idle bit after it
  task automatic sendByte(input byte_t b);
    expQ.push_back(b);
    holdBit(1'b0);
    for (int i = 0; i < 8; i++) begin
      holdBit(b[i]);
    end
    holdBit(1'b1);
    holdBit(1'b1);
  endtask

  task automatic sendBytes(input int n);
    byte_t b;
    for (int i = 0; i < n; i++) begin
      drawByte(b);
      sendByte(b);
    end
  endtask

  // ------------------------------------------------------------
  // card model
  // ------------------------------------------------------------

  task automatic serveBlocks(input int n);
    byte_t exp;
    for (int blk = 0; blk < n; blk++) begin
      do begin
        @(posedge clk);
      end while (!wrStart);
      compareSector("wrSector at wrStart", nextSector, wrSector);
      while (stall) @(posedge clk);
      // sample wrByte then take it
      // 4 cycles per byte
      for (int i = 0; i < blockLen; i++) begin
        if (expQ.size() == 0) begin
          abortRun("the block port delivered more bytes than were sent");
        end
        exp = expQ.pop_front();
        compareByte($sformatf("wrByte %0d of sector %0d", i, nextSector), exp, wrByte);
        byteTaken <= 1'b1;
        @(posedge clk);
        byteTaken <= 1'b0;
        repeat (3) @(posedge clk);
      end
      compareSector("wrSector before blockDone", nextSector, wrSector);
      blockDone <= 1'b1;
      @(posedge clk);
      blockDone <= 1'b0;
      while (blockBusy) @(posedge clk);
      nextSector = nextSector + sector_t'(1);
    end
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------

  task automatic expectResetState();
    compareBit("wrStart after reset", 1'b0, wrStart);
    compareBit("blockBusy after reset", 1'b0, blockBusy);
    compareBit("overflow after reset", 1'b0, overflow);
    compareCount("sectorsWritten after reset", 0, sectorsWritten);
    compareSector("wrSector after reset", firstSector, wrSector);
  endtask

  // one byte short of a block
  task automatic sendShortBlock();
    sendBytes(15);
    repeat (300) begin
      @(posedge clk);
      compareBit("wrStart with 15 bytes queued", 1'b0, wrStart);
      compareBit("blockBusy with 15 bytes queued", 1'b0, blockBusy);
    end
  endtask

  task automatic writeFirstBlock();
    fork
      sendBytes(1);
      serveBlocks(1);
    join
    compareCount("sectorsWritten after first block", 1, sectorsWritten);
    compareSector("wrSector after first block", firstSector + 1, wrSector);
  endtask

  task automatic streamTwoBlocks();
    fork
      sendBytes(32);
      serveBlocks(2);
    join
    compareCount("sectorsWritten after two blocks", 3, sectorsWritten);
    compareSector("wrSector after two blocks", firstSector + 3, wrSector);
    compareBit("overflow after two blocks", 1'b0, overflow);
  endtask

  // 15 queued plus 49 of the burst fill 64
  // the last 17 are dropped
  task automatic overrunFifo();
    stall = 1'b1;
    fork
      begin
        sendBytes(16);
        // busy means the pop of byte 0 is under way
        while (!blockBusy) @(posedge clk);
        compareBit("overflow before the burst", 1'b0, overflow);
        sendBytes(66);
        compareBit("overflow after the burst", 1'b1, overflow);
        stall = 1'b0;
      end
      serveBlocks(4);
    join
    compareCount("sectorsWritten after overflow", 7, sectorsWritten);
    compareSector("wrSector after overflow", firstSector + 7, wrSector);
    compareBit("overflow stays set", 1'b1, overflow);
  endtask

  initial begin
    rstn = 1'b0;
    rx = 1'b1;
    byteTaken = 1'b0;
    blockDone = 1'b0;
    lfsr = 16'd72;
    nextSector = firstSector;
    stall = 1'b0;
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    expectResetState();
    sendShortBlock();
    writeFirstBlock();
    streamTwoBlocks();
    overrunFifo();
    $display("Regression passed");
    $finish;
  end

endmodule

// File: filelist.f
logic/uartPkg.sv
logic/blockPkg.sv
logic/uartReceiver.sv
logic/byteFifo.sv
logic/sectorWriter.sv
logic/uartSectorLogger.sv
tb/uartSectorLoggerTb.sv
